// ==== axi_rd/axi_burst_reader.sv ====
`timescale 1ns/1ns

module axi_burst_reader
   import page_buf_pkg::*;
(
   input  logic              sysclk_i,
   input  logic              reset,
   input  logic              rd_go_i,
   input  logic [ADDR_W-1:0] rd_addr_i,
   output axi_ax_t           ar_o,
   output logic              arvalid_o,
   input  logic              arready_i,
   input  axi_r_t            r_i,
   input  logic              rvalid_i,
   output logic              rready_o,
   output logic              sink_we_o,
   output logic [DATA_W-1:0] sink_data_o,
   output logic              rd_busy_o,
   output logic              rd_done_o
);

   enum logic [1:0] {S_IDLE, S_ADDR, S_DATA} state_q;

   logic [ADDR_W-1:0] addr_q;
   // beats received so far in this burst
   logic [7:0]        beat_q;
   logic              done_q;
   logic              r_hs;

   assign arvalid_o = (state_q == S_ADDR);
   assign ar_o      = '{addr: addr_q, len: BURST_LEN, size: BURST_SIZE, burst: BURST_INCR};
   // ready from the AR handshake up to the last beat
   assign rready_o  = (state_q == S_DATA);
   assign r_hs      = rvalid_i && rready_o;
   assign rd_busy_o = (state_q != S_IDLE) || done_q;
   // lands together with the sink write of the last beat
   assign rd_done_o = done_q;

   always_ff @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         state_q   <= S_IDLE;
         beat_q    <= '0;
         done_q    <= 1'b0;
         sink_we_o <= 1'b0;
      end
      else
      begin
         // every accepted beat is written one cycle later
         sink_we_o <= r_hs;
         done_q    <= r_hs && r_i.last;
         case (state_q)
            S_IDLE:
            begin
               beat_q <= '0;
               if (rd_go_i)
                  state_q <= S_ADDR;
            end
            S_ADDR:
               if (arready_i)
                  state_q <= S_DATA;
            S_DATA:
               if (r_hs)
               begin
                  beat_q <= beat_q + 8'd1;
                  if (r_i.last)
                     state_q <= S_IDLE;
               end
            default:
               state_q <= S_IDLE;
         endcase
      end
   end

   // address and sink payload
   always_ff @(posedge sysclk_i)
   begin
      if (rd_go_i)
         addr_q <= rd_addr_i;
      if (r_hs)
         sink_data_o <= r_i.data;
   end

   // slave must close the burst on exactly beat BURST_BEATS
   a_last_on_final_beat: assert property (@(posedge sysclk_i) disable iff (reset)
      r_hs |-> (r_i.last == (beat_q == BURST_LEN)));

endmodule

// ==== axi_wr/axi_burst_writer.sv ====
`timescale 1ns/1ns

module axi_burst_writer
   import page_buf_pkg::*;
(
   input  logic              sysclk_i,
   input  logic              reset,
   input  logic              wr_go_i,
   input  logic [ADDR_W-1:0] wr_addr_i,
   input  logic              src_empty_i,
   input  logic [DATA_W-1:0] src_data_i,
   output logic              src_re_o,
   output axi_ax_t           aw_o,
   output logic              awvalid_o,
   input  logic              awready_i,
   output axi_w_t            w_o,
   output logic              wvalid_o,
   input  logic              wready_i,
   input  logic              bvalid_i,
   output logic              bready_o,
   output logic              wr_busy_o,
   output logic              wr_done_o
);

   enum logic [1:0] {S_IDLE, S_ADDR, S_DATA, S_RESP} state_q;

   logic [ADDR_W-1:0] addr_q;
   // beats already accepted in this burst
   logic [7:0]        beat_q;
   logic              done_q;
   logic              aw_hs;
   logic              w_hs;
   logic              w_last;

   //////////////////////////////////////////////////////////////////////
   // channel outputs
   //////////////////////////////////////////////////////////////////////

   assign awvalid_o = (state_q == S_ADDR);
   assign aw_o      = '{addr: addr_q, len: BURST_LEN, size: BURST_SIZE, burst: BURST_INCR};
   assign aw_hs     = awvalid_o && awready_i;

   // W data straight from the FIFO head, held back while starved
   assign wvalid_o  = (state_q == S_DATA) && !src_empty_i;
   assign w_last    = (beat_q == BURST_LEN);
   assign w_o       = '{data: src_data_i, strb: '1, last: w_last};
   assign w_hs      = wvalid_o && wready_i;
   // pop exactly the beat the slave took
   assign src_re_o  = w_hs;

   assign bready_o  = 1'b1;
   // the done cycle counts as busy so a new page never overlaps it
   assign wr_busy_o = (state_q != S_IDLE) || done_q;
   assign wr_done_o = done_q;

   //////////////////////////////////////////////////////////////////////
   // burst sequencing
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         state_q <= S_IDLE;
         beat_q  <= '0;
         done_q  <= 1'b0;
      end
      else
      begin
         done_q <= 1'b0;
         case (state_q)
            S_IDLE:
            begin
               beat_q <= '0;
               if (wr_go_i)
                  state_q <= S_ADDR;
            end
            S_ADDR:
               if (aw_hs)
                  state_q <= S_DATA;
            S_DATA:
               if (w_hs)
               begin
                  beat_q <= beat_q + 8'd1;
                  if (w_last)
                     state_q <= S_RESP;
               end
            // bready is always high, bvalid alone ends the write
            S_RESP:
               if (bvalid_i)
               begin
                  state_q <= S_IDLE;
                  done_q  <= 1'b1;
               end
            default:
               state_q <= S_IDLE;
         endcase
      end
   end

   // page address captured with the go strobe
   always_ff @(posedge sysclk_i)
   begin
      if (wr_go_i)
         addr_q <= wr_addr_i;
   end

   // AW payload must hold while the slave stalls
   a_aw_stable: assert property (@(posedge sysclk_i) disable iff (reset)
      awvalid_o && !awready_i |=> awvalid_o && $stable(aw_o));

   // a stalled W beat stays offered until the slave takes it
   a_w_stable: assert property (@(posedge sysclk_i) disable iff (reset)
      wvalid_o && !wready_i |=> wvalid_o && $stable(w_o));

endmodule

// ==== common/page_buf_pkg.sv ====
package page_buf_pkg;

   //////////////////////////////////////////////////////////////////////
   // burst geometry
   //////////////////////////////////////////////////////////////////////

   // beat width and byte strobes per beat
   localparam int DATA_W = 64;
   localparam int STRB_W = 8;

   // AXI byte address width
   localparam int ADDR_W = 32;

   // page counters, page target and page offset
   localparam int PAGE_CNT_W = 16;

   // one page is always one burst
   localparam int BURST_BEATS = 16;

   // AXI len field holds beats minus one
   localparam logic [7:0] BURST_LEN = 8'(BURST_BEATS - 1);

   // size code 3 means 8 bytes per beat
   localparam logic [2:0] BURST_SIZE = 3'd3;

   // incrementing burst
   localparam logic [1:0] BURST_INCR = 2'b01;

   // byte distance between consecutive pages
   localparam int PAGE_BYTES = BURST_BEATS * STRB_W;

   //////////////////////////////////////////////////////////////////////
   // AXI channel payloads
   //////////////////////////////////////////////////////////////////////

   // shared by AW and AR
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [7:0]        len;
      logic [2:0]        size;
      logic [1:0]        burst;
   } axi_ax_t;

   // write beat
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic              last;
   } axi_w_t;

   // read beat, resp is carried but not checked
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic [1:0]        resp;
      logic              last;
   } axi_r_t;

endpackage

// ==== dv/axi_mem_model.sv ====
`timescale 1ns/1ns

module axi_mem_model
   import page_buf_pkg::*;
(
   input  logic    sysclk_i,
   input  logic    reset,
   input  axi_ax_t aw_i,
   input  logic    awvalid_i,
   output logic    awready_o,
   input  axi_w_t  w_i,
   input  logic    wvalid_i,
   output logic    wready_o,
   output logic    bvalid_o,
   input  logic    bready_i,
   input  axi_ax_t ar_i,
   input  logic    arvalid_i,
   output logic    arready_o,
   output axi_r_t  r_o,
   output logic    rvalid_o,
   input  logic    rready_i
);

   // one word per byte address of a beat
   logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
   logic [ADDR_W-1:0] wptr;
   logic [ADDR_W-1:0] rptr;
   // beats still owed on the read burst
   int unsigned       rleft;
   logic              b_pend;
   logic [31:0]       rnd;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   initial
   begin
      rnd       = 32'd9663;
      rleft     = 0;
      b_pend    = 1'b0;
      awready_o = 1'b0;
      wready_o  = 1'b0;
      arready_o = 1'b0;
      bvalid_o  = 1'b0;
      rvalid_o  = 1'b0;
      r_o       = '0;
   end

   //////////////////////////////////////////////////////////////////////
   // handshakes, taken at the rising edge
   //////////////////////////////////////////////////////////////////////

   always @(posedge sysclk_i)
   begin
      if (reset)
      begin
         rleft  = 0;
         b_pend = 1'b0;
      end
      else
      begin
         if (awvalid_i && awready_o)
            wptr = aw_i.addr;
         if (wvalid_i && wready_o)
         begin
            mem[wptr] = w_i.data;
            wptr      = wptr + ADDR_W'(STRB_W);
            // B answers one cycle after the last beat
            if (w_i.last)
               b_pend = 1'b1;
         end
         if (bvalid_o && bready_i)
            b_pend = 1'b0;
         if (arvalid_i && arready_o)
         begin
            rptr  = ar_i.addr;
            rleft = BURST_BEATS;
         end
         if (rvalid_o && rready_i)
         begin
            rptr  = rptr + ADDR_W'(STRB_W);
            rleft = rleft - 1;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // outputs change on the falling edge
   //////////////////////////////////////////////////////////////////////

   always @(negedge sysclk_i)
   begin
      rnd = lcg_next(rnd);
      if (reset)
      begin
         awready_o = 1'b0;
         wready_o  = 1'b0;
         arready_o = 1'b0;
         bvalid_o  = 1'b0;
         rvalid_o  = 1'b0;
      end
      else
      begin
         // each ready drops about one cycle in four
         awready_o = (rnd[17:16] != 2'b00);
         wready_o  = (rnd[20:19] != 2'b00);
         arready_o = (rnd[23:22] != 2'b00);
         bvalid_o  = b_pend;
         // rready is held high by the master, so a beat is never withdrawn
         rvalid_o  = (rleft != 0) && (rnd[26:25] != 2'b00);
         if (rleft != 0)
         begin
            r_o.data = mem[rptr];
            r_o.resp = 2'b00;
            r_o.last = (rleft == 1);
         end
      end
   end

endmodule

// ==== dv/tb_page_buf.sv ====
`timescale 1ns/1ns

module tb_page_buf
   import page_buf_pkg::*;
();

   localparam logic [1:0] OP_WRITE = 2'd0;
   localparam logic [1:0] OP_READ  = 2'd1;
   localparam logic [1:0] OP_EMPTY = 2'd2;
   localparam logic [1:0] OP_FORCE = 2'd3;
   localparam int NUM_STEPS = 11;
   localparam logic [PAGE_CNT_W-1:0] TARGET = 16'd3;
   localparam logic [PAGE_CNT_W-1:0] OFFSET = 16'd5;

   // one step and the status expected once it has finished
   typedef struct packed {
      logic [1:0]            op;
      logic                  full;
      logic [PAGE_CNT_W-1:0] wr_pages;
      logic [PAGE_CNT_W-1:0] rd_pages;
   } step_t;

   step_t steps [NUM_STEPS] = '{
      '{OP_EMPTY, 1'b0, 16'd0, 16'd0},
      '{OP_WRITE, 1'b0, 16'd1, 16'd0},
      '{OP_WRITE, 1'b0, 16'd2, 16'd0},
      '{OP_WRITE, 1'b1, 16'd3, 16'd0},
      // buffer full, this one is dropped
      '{OP_WRITE, 1'b1, 16'd3, 16'd0},
      '{OP_READ,  1'b1, 16'd3, 16'd1},
      '{OP_READ,  1'b1, 16'd3, 16'd2},
      '{OP_READ,  1'b0, 16'd0, 16'd0},
      '{OP_WRITE, 1'b0, 16'd1, 16'd0},
      '{OP_FORCE, 1'b1, 16'd1, 16'd0},
      '{OP_READ,  1'b0, 16'd0, 16'd0}
   };

   logic                  sysclk_i;
   logic                  reset;
   logic                  write_req_i;
   logic                  read_req_i;
   logic                  force_rd_i;
   logic [PAGE_CNT_W-1:0] pages_target_i;
   logic [PAGE_CNT_W-1:0] mem_offset_i;
   logic                  src_empty_i = 1'b1;
   logic [DATA_W-1:0]     src_data_i = '0;
   logic                  src_re_o;
   logic                  sink_we_o;
   logic [DATA_W-1:0]     sink_data_o;
   logic                  full_o;
   logic                  empty_o;
   logic [PAGE_CNT_W-1:0] wr_pages_o;
   logic [PAGE_CNT_W-1:0] rd_pages_o;
   axi_ax_t               aw_o;
   logic                  awvalid_o;
   logic                  awready_i;
   axi_w_t                w_o;
   logic                  wvalid_o;
   logic                  wready_i;
   logic                  bvalid_i;
   logic                  bready_o;
   axi_ax_t               ar_o;
   logic                  arvalid_o;
   logic                  arready_i;
   axi_r_t                r_i;
   logic                  rvalid_i;
   logic                  rready_o;

   // running count of beats popped from the source
   int unsigned           pops = 0;
   // beat number shown on the head during the last cycle
   int unsigned           shown = 0;
   logic [31:0]           src_rnd = 32'd9663;
   // first source beat stored in each page slot
   int unsigned           slot_base [logic [PAGE_CNT_W-1:0]];
   logic [DATA_W-1:0]     exp_q [$];
   // beats taken so far in the current W burst
   int unsigned           w_beats = 0;
   // status the table expects after the step just run
   logic                  exp_full = 1'b0;
   logic [PAGE_CNT_W-1:0] exp_wr = '0;
   logic [PAGE_CNT_W-1:0] exp_rd = '0;

   page_buf_top DUT (.*);

   axi_mem_model u_mem (
      .sysclk_i  (sysclk_i),
      .reset     (reset),
      .aw_i      (aw_o),
      .awvalid_i (awvalid_o),
      .awready_o (awready_i),
      .w_i       (w_o),
      .wvalid_i  (wvalid_o),
      .wready_o  (wready_i),
      .bvalid_o  (bvalid_i),
      .bready_i  (bready_o),
      .ar_i      (ar_o),
      .arvalid_i (arvalid_o),
      .arready_o (arready_i),
      .r_o       (r_i),
      .rvalid_o  (rvalid_i),
      .rready_i  (rready_o)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // source beat k of the whole run
   function automatic logic [DATA_W-1:0] beat_pattern(input logic [31:0] k);
      return {16'hC0DE, k[15:0], k * 32'h9E3779B1};
   endfunction

   task automatic fail_now(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "run stopped on first error");
   endtask

   task automatic check_val(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
      assert (got === exp)
      else fail_now($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
   endtask

   //////////////////////////////////////////////////////////////////////
   // clock, source FIFO and sink monitor
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      sysclk_i = 1'b0;
      forever #20 sysclk_i = ~sysclk_i;
   end

   // show-ahead head, may run dry only once its beat was popped
   always @(negedge sysclk_i)
   begin
      src_rnd = lcg_next(src_rnd);
      if (src_empty_i || (pops != shown))
         src_empty_i = (src_rnd[18:17] == 2'b00);
      shown      = pops;
      src_data_i = beat_pattern(pops);
   end

   always @(posedge sysclk_i)
   begin
      if (!reset && src_re_o)
         pops++;
      if (!reset && sink_we_o)
      begin
         assert (exp_q.size() != 0)
         else fail_now("sink write arrived while no read beat was pending");
         check_val("sink_data_o", sink_data_o, exp_q.pop_front());
      end
   end

   //////////////////////////////////////////////////////////////////////
   // AXI channel fields
   //////////////////////////////////////////////////////////////////////

   // len is beats minus one, size is log2 of the beat bytes, INCR is 01
   always @(posedge sysclk_i)
   begin
      if (!reset && awvalid_o && awready_i)
      begin
         w_beats = 0;
         check_val("aw_o.len", DATA_W'(aw_o.len), DATA_W'(BURST_BEATS - 1));
         check_val("aw_o.size", DATA_W'(aw_o.size), DATA_W'($clog2(STRB_W)));
         check_val("aw_o.burst", DATA_W'(aw_o.burst), DATA_W'(2'b01));
      end
      if (!reset && wvalid_o && wready_i)
      begin
         check_val("w_o.strb", DATA_W'(w_o.strb), DATA_W'({STRB_W{1'b1}}));
         check_val("w_o.last", DATA_W'(w_o.last), DATA_W'(w_beats == BURST_BEATS - 1));
         w_beats++;
      end
      if (!reset && bvalid_i)
         check_val("bready_o", DATA_W'(bready_o), DATA_W'(1'b1));
      if (!reset && arvalid_o && arready_i)
      begin
         check_val("ar_o.len", DATA_W'(ar_o.len), DATA_W'(BURST_BEATS - 1));
         check_val("ar_o.size", DATA_W'(ar_o.size), DATA_W'($clog2(STRB_W)));
         check_val("ar_o.burst", DATA_W'(ar_o.burst), DATA_W'(2'b01));
      end
   end

   //////////////////////////////////////////////////////////////////////
   // step execution
   //////////////////////////////////////////////////////////////////////

   task automatic run_step(input step_t st);
      logic [PAGE_CNT_W-1:0] page;
      logic [ADDR_W-1:0]     addr;
      logic                  launch;
      int unsigned           base;
      case (st.op)
         OP_WRITE:
         begin
            page        = exp_wr;
            base        = pops;
            launch      = !exp_full;
            write_req_i = 1'b1;
            @(negedge sysclk_i);
            write_req_i = 1'b0;
            if (launch)
            begin
               slot_base[page] = base;
               while (DUT.wr_busy)
                  @(negedge sysclk_i);
               // page lands at PAGE_BYTES times page index plus offset
               addr = (ADDR_W'(page) + ADDR_W'(OFFSET)) * ADDR_W'(PAGE_BYTES);
               for (int k = 0; k < BURST_BEATS; k++)
                  check_val("mem word", u_mem.mem[addr + ADDR_W'(k * STRB_W)],
                            beat_pattern(base + k));
            end
         end
         OP_READ:
         begin
            page = exp_rd;
            for (int k = 0; k < BURST_BEATS; k++)
               exp_q.push_back(beat_pattern(slot_base[page] + k));
            read_req_i = 1'b1;
            @(negedge sysclk_i);
            read_req_i = 1'b0;
            // the release lands on the edge of the last sink beat
            while (exp_q.size() != 0)
               @(negedge sysclk_i);
         end
         OP_EMPTY:
         begin
            read_req_i = 1'b1;
            @(negedge sysclk_i);
            read_req_i = 1'b0;
            check_val("empty_o", DATA_W'(empty_o), DATA_W'(1'b1));
            @(negedge sysclk_i);
            check_val("empty_o", DATA_W'(empty_o), DATA_W'(1'b0));
         end
         default:
         begin
            force_rd_i = 1'b1;
            @(negedge sysclk_i);
            force_rd_i = 1'b0;
            while (!full_o)
               @(negedge sysclk_i);
         end
      endcase
      check_val("full_o", DATA_W'(full_o), DATA_W'(st.full));
      check_val("wr_pages_o", DATA_W'(wr_pages_o), DATA_W'(st.wr_pages));
      check_val("rd_pages_o", DATA_W'(rd_pages_o), DATA_W'(st.rd_pages));
      exp_full = st.full;
      exp_wr   = st.wr_pages;
      exp_rd   = st.rd_pages;
   endtask

   initial
   begin
      reset          = 1'b1;
      write_req_i    = 1'b0;
      read_req_i     = 1'b0;
      force_rd_i     = 1'b0;
      pages_target_i = TARGET;
      mem_offset_i   = OFFSET;
      repeat (10)
         @(posedge sysclk_i);
      @(negedge sysclk_i);
      reset = 1'b0;
      @(negedge sysclk_i);
      check_val("full_o", DATA_W'(full_o), '0);
      check_val("empty_o", DATA_W'(empty_o), '0);
      check_val("wr_pages_o", DATA_W'(wr_pages_o), '0);
      check_val("rd_pages_o", DATA_W'(rd_pages_o), '0);
      for (int i = 0; i < NUM_STEPS; i++)
         run_step(steps[i]);
      $display("TEST PASSED");
      $finish;
   end

   // worst case per step plus the reset cycles
   initial
   begin
      repeat (10 + NUM_STEPS * (BURST_BEATS * 8 + 50))
         @(posedge sysclk_i);
      fail_now("timeout, the step table did not complete in the allowed cycles");
   end

endmodule

// ==== hw/page_buf_top.sv ====
`timescale 1ns/1ns

module page_buf_top
   import page_buf_pkg::*;
(
   input  logic                  sysclk_i,
   input  logic                  reset,
   input  logic                  write_req_i,
   input  logic                  read_req_i,
   input  logic                  force_rd_i,
   input  logic [PAGE_CNT_W-1:0] pages_target_i,
   input  logic [PAGE_CNT_W-1:0] mem_offset_i,
   // show-ahead source FIFO
   input  logic                  src_empty_i,
   input  logic [DATA_W-1:0]     src_data_i,
   output logic                  src_re_o,
   // sink port
   output logic                  sink_we_o,
   output logic [DATA_W-1:0]     sink_data_o,
   // status
   output logic                  full_o,
   output logic                  empty_o,
   output logic [PAGE_CNT_W-1:0] wr_pages_o,
   output logic [PAGE_CNT_W-1:0] rd_pages_o,
   // AXI master
   output axi_ax_t               aw_o,
   output logic                  awvalid_o,
   input  logic                  awready_i,
   output axi_w_t                w_o,
   output logic                  wvalid_o,
   input  logic                  wready_i,
   input  logic                  bvalid_i,
   output logic                  bready_o,
   output axi_ax_t               ar_o,
   output logic                  arvalid_o,
   input  logic                  arready_i,
   input  axi_r_t                r_i,
   input  logic                  rvalid_i,
   output logic                  rready_o
);

   // ledger to engines
   logic              wr_go;
   logic              rd_go;
   logic [ADDR_W-1:0] wr_addr;
   logic [ADDR_W-1:0] rd_addr;
   // engines back to ledger
   logic              wr_busy;
   logic              wr_done;
   logic              rd_busy;
   logic              rd_done;

   // bookkeeping, decides which page goes where
   page_ledger u_ledger (
      .wr_busy_i (wr_busy),
      .wr_done_i (wr_done),
      .rd_busy_i (rd_busy),
      .rd_done_i (rd_done),
      .wr_go_o   (wr_go),
      .rd_go_o   (rd_go),
      .wr_addr_o (wr_addr),
      .rd_addr_o (rd_addr),
      .*
   );

   // FIFO to memory
   axi_burst_writer u_writer (
      .wr_go_i   (wr_go),
      .wr_addr_i (wr_addr),
      .wr_busy_o (wr_busy),
      .wr_done_o (wr_done),
      .*
   );

   // memory to sink
   axi_burst_reader u_reader (
      .rd_go_i   (rd_go),
      .rd_addr_i (rd_addr),
      .rd_busy_o (rd_busy),
      .rd_done_o (rd_done),
      .*
   );

endmodule

// ==== hw/page_ledger.sv ====
`timescale 1ns/1ns

module page_ledger
   import page_buf_pkg::*;
(
   input  logic                  sysclk_i,
   input  logic                  reset,
   input  logic                  write_req_i,
   input  logic                  read_req_i,
   input  logic                  force_rd_i,
   input  logic [PAGE_CNT_W-1:0] pages_target_i,
   input  logic [PAGE_CNT_W-1:0] mem_offset_i,
   input  logic                  wr_busy_i,
   input  logic                  wr_done_i,
   input  logic                  rd_busy_i,
   input  logic                  rd_done_i,
   output logic                  wr_go_o,
   output logic                  rd_go_o,
   output logic [ADDR_W-1:0]     wr_addr_o,
   output logic [ADDR_W-1:0]     rd_addr_o,
   output logic                  full_o,
   output logic                  empty_o,
   output logic [PAGE_CNT_W-1:0] wr_pages_o,
   output logic [PAGE_CNT_W-1:0] rd_pages_o
);

   // pages to read before the buffer is released
   logic [PAGE_CNT_W-1:0] rd_target_q;
   logic                  fill_w;
   logic                  release_w;

   // byte address of a page, offset counted in pages
   function automatic logic [ADDR_W-1:0] page_addr(input logic [PAGE_CNT_W-1:0] page,
                                                   input logic [PAGE_CNT_W-1:0] offset);
      logic [ADDR_W-1:0] idx;
      idx = ADDR_W'(page) + ADDR_W'(offset);
      return idx * ADDR_W'(PAGE_BYTES);
   endfunction

   // requests are dropped while the engine is busy
   assign wr_go_o   = write_req_i && !full_o && !wr_busy_i;
   assign rd_go_o   = read_req_i && full_o && !rd_busy_i;
   // counters still hold the pre-increment value with the go strobe
   assign wr_addr_o = page_addr(wr_pages_o, mem_offset_i);
   assign rd_addr_o = page_addr(rd_pages_o, mem_offset_i);
   // wr_pages_o already counts the page that just finished
   assign fill_w    = wr_done_i && (wr_pages_o == pages_target_i);
   assign release_w = rd_done_i && (rd_pages_o == rd_target_q);

   always_ff @(posedge sysclk_i or posedge reset)
   begin
      if (reset)
      begin
         full_o      <= 1'b0;
         empty_o     <= 1'b0;
         wr_pages_o  <= '0;
         rd_pages_o  <= '0;
         rd_target_q <= '0;
      end
      else
      begin
         // one-cycle answer to a read with nothing stored
         empty_o <= read_req_i && !full_o;
         if (release_w)
         begin
            // last page out, open the buffer again
            full_o     <= 1'b0;
            wr_pages_o <= '0;
            rd_pages_o <= '0;
         end
         else
         begin
            if (wr_go_o)
               wr_pages_o <= wr_pages_o + PAGE_CNT_W'(1);
            if (force_rd_i)
            begin
               // make whatever is stored readable now
               full_o      <= 1'b1;
               rd_pages_o  <= '0;
               rd_target_q <= wr_pages_o;
            end
            else
            begin
               if (rd_go_o)
                  rd_pages_o <= rd_pages_o + PAGE_CNT_W'(1);
               if (fill_w)
               begin
                  full_o      <= 1'b1;
                  rd_target_q <= pages_target_i;
               end
            end
         end
      end
   end

   // no page is launched beyond the write target
   a_no_write_past_target: assert property (@(posedge sysclk_i) disable iff (reset)
      wr_go_o |-> (wr_pages_o < pages_target_i));

endmodule

// ==== page_buf.f ====
common/page_buf_pkg.sv
hw/page_ledger.sv
axi_wr/axi_burst_writer.sv
axi_rd/axi_burst_reader.sv
hw/page_buf_top.sv
dv/axi_mem_model.sv
dv/tb_page_buf.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the page buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_page_buf \
   -f page_buf.f \
   --Mdir obj_dir -o sim_page_buf
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/sim_page_buf
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit 1
fi

exit 0
